//--- source/board_pkg.sv
package board_pkg;

    //------------------------------------------------------------
    // Widths that carry a meaning

    typedef logic [ 7:0] seg_t;      // One digit, abcdefgh, segment a at bit 7
    typedef logic [ 7:0] key_vec_t;  // TM1638 keys, board keys ORed into low bits
    typedef logic [ 7:0] led_vec_t;  // TM1638 LEDs, low four also on the board
    typedef logic [31:0] count_t;    // Eight hex digits
    typedef logic [ 7:0] tm_cmd_t;   // One byte on the serial bus

    // Everything the display shows in one refresh
    typedef struct packed {
        seg_t [7:0] digits;          // Digit 0 is the rightmost one
        led_vec_t   leds;
    } disp_frame_t;

    //------------------------------------------------------------
    // TM1638 command bytes

    localparam tm_cmd_t cmd_write_auto = 8'h40;  // Data write, address auto increment
    localparam tm_cmd_t cmd_read_keys  = 8'h42;  // Key scan read
    localparam tm_cmd_t cmd_addr0      = 8'hc0;  // Start address 0
    localparam tm_cmd_t cmd_display_on = 8'h8f;  // Display on, full brightness

    //------------------------------------------------------------
    // Hex digit to segments, abcdefgh

    localparam seg_t hex_seg [0:15] = '{
        8'b1111_1100,  // 0
        8'b0110_0000,  // 1
        8'b1101_1010,  // 2
        8'b1111_0010,  // 3
        8'b0110_0110,  // 4
        8'b1011_0110,  // 5
        8'b1011_1110,  // 6
        8'b1110_0000,  // 7
        8'b1111_1110,  // 8
        8'b1111_0110,  // 9
        8'b1110_1110,  // A
        8'b0011_1110,  // b
        8'b1001_1100,  // C
        8'b0111_1010,  // d
        8'b1001_1110,  // E
        8'b1000_1110   // F
    };

endpackage

//--- source/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
    parameter clk_mhz = 125,  // Main clock frequency
    parameter tick_hz = 1     // Strobe rate
) (
    input  logic clk,
    input  logic reset,
    output logic tick         // One cycle wide
);

    localparam int ratio = clk_mhz * 1000000 / tick_hz;     // Cycles per tick
    localparam int w_cnt = (ratio > 2) ? $clog2(ratio) : 1;

    logic [w_cnt - 1:0] cnt;  // Cycles left until the next tick

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= w_cnt'(ratio - 1);
            tick <= 1'b0;
        end else begin
            tick <= (cnt == '0);                  // Pulse as the count runs out
            if (cnt == '0)
                cnt <= w_cnt'(ratio - 1);         // Reload, period is ratio
            else
                cnt <= cnt - 1'b1;
        end
    end

    //------------------------------------------------------------

    // A strobe, never a level
    tick_single_cycle: assert property (
        @(posedge clk) disable iff (reset) tick |=> !tick
    );

endmodule

//--- source/key_merge.sv
`timescale 1ns/1ps

module key_merge #(
    parameter w_key = 4                     // Number of board keys
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [w_key - 1:0]   key,       // Board keys, asynchronous
    input  board_pkg::key_vec_t  tm_keys,   // Keys read back from the TM1638
    output board_pkg::key_vec_t  keys       // Merged key vector
);

    logic [w_key - 1:0] key_meta;  // First synchronizer stage
    logic [w_key - 1:0] key_sync;  // Second stage, safe to use

    //------------------------------------------------------------
    // Two flop synchronizer

    always_ff @(posedge clk) begin
        if (reset) begin
            key_meta <= '0;
            key_sync <= '0;
        end else begin
            key_meta <= key;
            key_sync <= key_meta;
        end
    end

    //------------------------------------------------------------
    // Duplicate mode, board keys share the low bits

    always_comb begin
        keys = tm_keys;
        keys = keys | board_pkg::key_vec_t'(key_sync);  // Zero extended
    end

    // More board keys than merged bits would silently drop some
    key_width_fits: assert property (
        @(posedge clk) w_key <= $bits(board_pkg::key_vec_t)
    );

endmodule

//--- source/lab_counter.sv
`timescale 1ns/1ps

module lab_counter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   tick,    // Advance strobe
    input  board_pkg::key_vec_t    keys,    // Merged keys, key 0 clears
    output board_pkg::disp_frame_t frame    // Digits and LEDs for the display
);

    board_pkg::count_t count;   // Hex counter value
    logic              key0_q;  // Key 0 one cycle ago
    logic              clear;   // Key 0 rising edge

    assign clear = keys[0] & ~key0_q;

    //------------------------------------------------------------
    // Counter

    always_ff @(posedge clk) begin
        if (reset) begin
            count  <= '0;
            key0_q <= 1'b0;
        end else begin
            key0_q <= keys[0];
            if (clear)
                count <= '0;                // Clear wins over a tick
            else if (tick)
                count <= count + 1'b1;
        end
    end

    //------------------------------------------------------------
    // Display frame, one cycle behind count

    always_ff @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            frame.digits[i] <= board_pkg::hex_seg[count[4 * i +: 4]];  // Nibble i, digit i
        end
        frame.leds <= keys;                 // LEDs mirror the keys
    end

    //------------------------------------------------------------

    // Nothing but a tick or a clear moves the count
    count_moves_on_cause: assert property (
        @(posedge clk) disable iff (reset)
            $changed(count) |-> $past(tick || clear)
    );

endmodule

//--- source/tm1638_controller.sv
`timescale 1ns/1ps

module tm1638_controller #(
    parameter clk_mhz = 125                        // Main clock frequency
) (
    input  logic                   clk,
    input  logic                   reset,
    input  board_pkg::disp_frame_t frame,          // Sampled once per refresh
    output board_pkg::key_vec_t    tm_keys,        // Key scan result
    output logic                   sio_clk,
    output logic                   sio_stb,
    inout  wire                    sio_data
);

    localparam int half_cycles = (clk_mhz >= 2) ? clk_mhz / 2 : 1;  // About 0.5 us
    localparam int w_half      = (half_cycles > 2) ? $clog2(half_cycles) : 1;

    typedef enum logic [2:0] {
        st_idle, st_command, st_write_data, st_display_on, st_read_keys, st_gap
    } state_t;

    state_t                 state;
    logic [1:0]             grp;        // Group of the refresh cycle, 0 to 3
    logic [3:0]             byte_cnt;   // Data byte within the group
    logic [3:0]             rise_cnt;   // Rising sio_clk edges in this byte
    logic [w_half - 1:0]    half_cnt;   // Cycles left in this half bit
    logic [7:0]             shift;      // Out LSB first, read bits enter at top
    logic                   data_out;   // Bit on the wire
    logic                   data_oe;    // Controller owns sio_data
    logic                   scan_done;  // Refresh finished, keys complete
    board_pkg::key_vec_t    key_acc;    // Keys gathered during the read group
    board_pkg::disp_frame_t frame_q;    // Frame of the running refresh
    board_pkg::tm_cmd_t     group_cmd;  // First byte of the next group
    board_pkg::tm_cmd_t     next_data;  // Next display byte
    logic [3:0]             next_addr;

    assign sio_data = data_oe ? data_out : 1'bz;   // Released while the chip talks

    //------------------------------------------------------------
    // Display memory bytes

    function automatic board_pkg::tm_cmd_t data_byte(
        input board_pkg::disp_frame_t f,
        input logic [3:0]             addr
    );
        logic [2:0]         pos;
        board_pkg::seg_t    seg;
        board_pkg::tm_cmd_t rev;
        pos = 3'd7 - addr[3:1];                    // Address 0 is the leftmost place
        seg = f.digits[pos];
        rev = {<<{seg}};                           // Chip wants hgfedcba
        return addr[0] ? board_pkg::tm_cmd_t'(f.leds[pos]) : rev;  // Odd, LED in bit 0
    endfunction

    assign next_addr = (state == st_command) ? 4'd0 : byte_cnt + 4'd1;
    assign next_data = data_byte(frame_q, next_addr);

    always_comb begin
        case (grp)
            2'd0:    group_cmd = board_pkg::cmd_write_auto;
            2'd1:    group_cmd = board_pkg::cmd_addr0;
            2'd2:    group_cmd = board_pkg::cmd_display_on;
            default: group_cmd = board_pkg::cmd_read_keys;
        endcase
    end

    //------------------------------------------------------------
    // Refresh FSM and bit engine, stepping once per half bit

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            grp       <= 2'd0;
            byte_cnt  <= '0;
            rise_cnt  <= '0;
            half_cnt  <= '0;
            sio_clk   <= 1'b1;
            sio_stb   <= 1'b1;
            data_oe   <= 1'b0;
            scan_done <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            if (half_cnt != '0) begin
                half_cnt <= half_cnt - 1'b1;
            end else begin
                half_cnt <= w_half'(half_cycles - 1);
                case (state)
                    st_idle, st_gap: begin
                        if (state == st_idle)
                            frame_q <= frame;            // One frame per refresh
                        if (state == st_gap && grp == 2'd0) begin
                            state <= st_idle;
                        end else begin                   // Open the next group
                            sio_stb  <= 1'b0;
                            shift    <= group_cmd;
                            data_out <= group_cmd[0];
                            data_oe  <= 1'b1;
                            rise_cnt <= '0;
                            state    <= (grp == 2'd2) ? st_display_on : st_command;
                        end
                    end
                    default: begin
                        if (!sio_clk) begin              // Rising edge, sample
                            sio_clk  <= 1'b1;
                            shift    <= {sio_data, shift[7:1]};
                            rise_cnt <= rise_cnt + 1'b1;
                        end else if (rise_cnt != 4'd8) begin
                            sio_clk  <= 1'b0;            // Falling edge, next bit out
                            data_out <= shift[0];
                        end else begin                   // Byte complete
                            rise_cnt <= '0;
                            if (state == st_read_keys) begin
                                key_acc[{byte_cnt[1:0], 1'b0}] <= shift[0];
                                key_acc[{byte_cnt[1:0], 1'b1}] <= shift[4];
                            end
                            if ((state == st_command && grp == 2'd1) ||
                                (state == st_write_data && byte_cnt != 4'd15)) begin
                                sio_clk  <= 1'b0;        // Next display byte
                                shift    <= next_data;
                                data_out <= next_data[0];
                                byte_cnt <= next_addr;
                                state    <= st_write_data;
                            end else if ((state == st_command && grp == 2'd3) ||
                                         (state == st_read_keys && byte_cnt != 4'd3)) begin
                                sio_clk  <= 1'b0;        // Chip drives the next key byte
                                data_oe  <= 1'b0;
                                byte_cnt <= (state == st_command) ? 4'd0 : byte_cnt + 4'd1;
                                state    <= st_read_keys;
                            end else begin               // Close the group
                                sio_stb   <= 1'b1;
                                data_oe   <= 1'b0;
                                grp       <= grp + 1'b1;
                                scan_done <= (state == st_read_keys);
                                state     <= st_gap;
                            end
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            tm_keys <= '0;
        else if (scan_done)
            tm_keys <= key_acc;                          // Whole scan at once
    end

    //------------------------------------------------------------

    // The chip owns the line for every key byte
    release_on_read: assert property (
        @(posedge clk) disable iff (reset) (state == st_read_keys) |-> !data_oe
    );

    // One command group is framed by a single strobe pulse
    stb_holds_group: assert property (
        @(posedge clk) disable iff (reset)
            $fell(sio_stb) |-> !sio_stb until (state == st_gap)
    );

endmodule

//--- source/board_top.sv
`timescale 1ns/1ps

module board_top #(
    parameter clk_mhz = 125,       // Main clock frequency
    parameter tick_hz = 2,         // Counter rate
    parameter w_key   = 4          // Number of board keys
) (
    input  logic [w_key - 1:0] key,
    input  logic               clk,
    input  logic [3:0]         sw,
    output logic [3:0]         led,
    inout  wire  [7:0]         gpio  // Pmod, TM1638 on the low three pins
);

    wire reset = sw[3];            // Last switch is the reset

    //------------------------------------------------------------

    logic                   tick;
    board_pkg::key_vec_t    keys;
    board_pkg::key_vec_t    tm_keys;
    board_pkg::disp_frame_t frame;

    tick_gen #(
        .clk_mhz (clk_mhz),
        .tick_hz (tick_hz)
    ) i_tick_gen (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick)
    );

    key_merge #(
        .w_key   (w_key)
    ) i_key_merge (
        .clk     (clk),
        .reset   (reset),
        .key     (key),
        .tm_keys (tm_keys),
        .keys    (keys)
    );

    lab_counter i_lab_counter (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick),
        .keys    (keys),
        .frame   (frame)
    );

    //------------------------------------------------------------

    tm1638_controller #(
        .clk_mhz  (clk_mhz)
    ) i_tm1638 (
        .clk      (clk),
        .reset    (reset),
        .frame    (frame),
        .tm_keys  (tm_keys),
        .sio_stb  (gpio[0]),
        .sio_clk  (gpio[1]),
        .sio_data (gpio[2])
    );

    assign led       = frame.leds[3:0];  // Board LEDs share the low TM1638 bits
    assign gpio[7:3] = 'z;               // Free Pmod pins released

endmodule

//--- dv/tm1638_model.sv
`timescale 1ns/1ps

module tm1638_model (
    input  logic                   sio_stb,
    input  logic                   sio_clk,
    inout  wire                    sio_data,
    input  board_pkg::key_vec_t    pressed,      // Keys held on the module
    output board_pkg::disp_frame_t shown,        // Frame decoded at the last refresh
    output int                     refresh_cnt,  // Completed refreshes
    output logic                   proto_err     // Bus rule broken
);

    logic [7:0] mem [0:15];   // Display memory
    logic [7:0] sh;           // Incoming byte, LSB first
    logic [7:0] group_cmd;    // First byte of the group
    logic [3:0] addr;         // Write address, auto increment
    int         bit_cnt;
    int         byte_cnt;     // Bytes so far, command included
    logic       reading;      // Key read group
    logic       drive_en;
    logic       drive_bit;
    realtime    last_change;  // Last sio_data edge

    assign sio_data = drive_en ? drive_bit : 1'bz;

    initial begin
        drive_en    = 1'b0;
        drive_bit   = 1'b1;
        proto_err   = 1'b0;
        refresh_cnt = 0;
        reading     = 1'b0;
        bit_cnt     = 0;
        byte_cnt    = 0;
        last_change = 0.0;
        shown       = '0;
        for (int i = 0; i < 16; i++)
            mem[i] = 8'h00;
    end

    always @(sio_data)
        last_change = $realtime;

    task automatic protocol_violation(input string what);
        $display("TM1638 model: %s at %0t", what, $realtime);
        proto_err = 1'b1;
    endtask

    // Byte k of a key read, key 2k in bit 0 and key 2k+1 in bit 4
    function automatic logic [7:0] key_byte(input board_pkg::key_vec_t p, input int k);
        logic [7:0] b;
        b    = 8'h00;
        b[0] = p[2 * k];
        b[4] = p[2 * k + 1];
        return b;
    endfunction

    //------------------------------------------------------------
    // Serial decode

    always @(negedge sio_stb) begin
        bit_cnt  = 0;
        byte_cnt = 0;
        reading  = 1'b0;
    end

    always @(posedge sio_clk) begin
        if (!sio_stb) begin
            bit_stable: assert (last_change != $realtime && sio_data !== 1'bx)
                else protocol_violation("sio_data not settled at rising sio_clk");
            sh = {sio_data, sh[7:1]};
            bit_cnt++;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                if (byte_cnt == 0) begin
                    group_cmd = sh;
                    addr      = sh[3:0];
                    reading   = (sh[7:6] == 2'b01) && sh[1];  // Data command, read mode
                end else if (!reading && group_cmd[7:6] == 2'b11) begin
                    mem[addr] = sh;
                    addr++;
                end
                byte_cnt++;
            end
        end
        drive_en = 1'b0;                                       // Bit taken, line released
    end

    always @(negedge sio_clk) begin
        if (!sio_stb && reading && byte_cnt >= 1 && byte_cnt <= 4) begin
            sh        = key_byte(pressed, byte_cnt - 1);
            drive_bit = sh[bit_cnt];
            drive_en  = 1'b1;                                  // Chip talks while clock is low
        end
    end

    //------------------------------------------------------------
    // End of group

    always @(posedge sio_stb) begin
        if (byte_cnt > 0) begin
            whole_bytes: assert (bit_cnt == 0)
                else protocol_violation("group ended inside a byte");
            if (group_cmd[7:6] == 2'b11) begin
                write_len: assert (byte_cnt == 17)
                    else protocol_violation("write group did not hold 16 data bytes");
            end
            if (reading) begin                                 // Read closes the refresh
                for (int p = 0; p < 8; p++) begin
                    for (int b = 0; b < 8; b++)
                        shown.digits[p][7 - b] = mem[2 * (7 - p)][b];  // hgfedcba on the bus
                    shown.leds[p] = mem[2 * (7 - p) + 1][0];
                end
                refresh_cnt++;
            end
        end
        reading = 1'b0;
    end

endmodule

//--- dv/tb_board_top.sv
`timescale 1ns/1ps

module tb_board_top;

    localparam int clk_mhz = 1;
    localparam int tick_hz = 2000;
    localparam int w_key   = 4;

    localparam int ratio           = clk_mhz * 1000000 / tick_hz;       // Cycles per tick
    localparam int half_bit        = (clk_mhz >= 2) ? clk_mhz / 2 : 1;  // Cycles per half bit
    localparam int refresh_cycles  = 24 * (18 * half_bit) + 8;          // 24 bytes per refresh
    localparam int watchdog_cycles = 40 * refresh_cycles + 20 * ratio;

    logic                   clk;
    logic [w_key - 1:0]     key;
    logic [3:0]             sw;
    logic [3:0]             led;
    wire  [7:0]             gpio;
    board_pkg::key_vec_t    pressed;          // TM1638 keys held
    board_pkg::disp_frame_t shown;
    int                     refresh_cnt;
    logic                   proto_err;

    int                     cycle = 0;        // Clock cycles since start
    int                     clear_window;     // Refreshes that may still show a clear
    board_pkg::count_t      prev_value;
    int                     prev_cycle;
    int                     press_cycle;
    board_pkg::key_vec_t    tm_pat;
    logic [w_key - 1:0]     board_pat;

    pullup (gpio[2]);

    board_top #(
        .clk_mhz (clk_mhz),
        .tick_hz (tick_hz),
        .w_key   (w_key)
    ) UUT (
        .key     (key),
        .clk     (clk),
        .sw      (sw),
        .led     (led),
        .gpio    (gpio)
    );

    tm1638_model tm1638 (
        .sio_stb     (gpio[0]),
        .sio_clk     (gpio[1]),
        .sio_data    (gpio[2]),
        .pressed     (pressed),
        .shown       (shown),
        .refresh_cnt (refresh_cnt),
        .proto_err   (proto_err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    //------------------------------------------------------------
    // Failure exits

    task automatic wrong_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        $display("Verification failed");
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic abort_run(input string what);
        $display("Error: %s", what);
        $display("Verification failed");
        $fatal(1, "%s", what);
    endtask

    always @(posedge proto_err)
        abort_run("TM1638 bus protocol broken");

    initial begin
        #(watchdog_cycles * 10);
        abort_run("timeout, the tests did not finish in time");
    end

    //------------------------------------------------------------
    // Display decode and refresh checks

    function automatic int seg_nibble(input board_pkg::seg_t s);
        for (int n = 0; n < 16; n++)
            if (board_pkg::hex_seg[n] == s)
                return n;
        return -1;                                      // Not a hex digit
    endfunction

    function automatic board_pkg::count_t frame_value(input board_pkg::disp_frame_t f);
        board_pkg::count_t v;
        int                n;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            n = seg_nibble(f.digits[i]);
            v[4 * i +: 4] = n[3:0];                     // Digit 0 is the low nibble
        end
        return v;
    endfunction

    task automatic check_refresh();
        board_pkg::count_t value;
        int                ticks;
        for (int i = 0; i < 8; i++) begin
            digit_is_hex: assert (seg_nibble(shown.digits[i]) >= 0)
                else abort_run($sformatf("digit %0d shows 0x%02h, no hex pattern",
                                         i, shown.digits[i]));
        end
        value = frame_value(shown);
        ticks = (cycle - prev_cycle) / ratio;           // Whole ticks since the last refresh
        if (clear_window > 0) begin
            clear_window--;                             // A clear may land here
        end else begin
            count_kept: assert (value >= prev_value)
                else wrong_value("display value", value, prev_value);
            count_step: assert (value <= prev_value + ticks + 1)
                else wrong_value("display value upper bound", value, prev_value + ticks + 1);
        end
        prev_value = value;
        prev_cycle = cycle;
    endtask

    always @(refresh_cnt)
        if (refresh_cnt > 0)
            check_refresh();

    //------------------------------------------------------------
    // Stimulus helpers

    task automatic next_refresh_start();
        @(refresh_cnt);
        @(posedge clk);
    endtask

    task automatic expect_leds(input board_pkg::led_vec_t exp, input int max_refreshes);
        int n;
        n = 0;
        while (shown.leds !== exp && n < max_refreshes) begin
            @(refresh_cnt);
            n++;
        end
        tm_leds_arrive: assert (shown.leds === exp)
            else wrong_value("TM1638 leds", shown.leds, exp);
        @(negedge clk);
        board_leds: assert (led === exp[3:0])
            else wrong_value("led", led, exp[3:0]);
    endtask

    task automatic check_cleared(input int since);
        board_pkg::count_t value;
        int                ticks;
        value = frame_value(shown);
        ticks = (cycle - since) / ratio + 1;
        cleared_value: assert (value <= ticks)
            else wrong_value("display value after key 0", value, ticks);
    endtask

    //------------------------------------------------------------
    // Main sequence

    initial begin
        void'($urandom(32'hae8f_1cb8));
        key          = '0;
        sw           = 4'b1000;                         // Reset held by the last switch
        pressed      = '0;
        clear_window = 0;
        prev_value   = '0;
        prev_cycle   = 0;
        repeat (2) @(posedge clk);
        sw <= 4'b0000;

        @(negedge clk);
        while (gpio[0] !== 1'b0) begin                  // Quiet bus until the first group
            bus_idle: assert (gpio[1] === 1'b1 && led === 4'h0)
                else wrong_value("sio_clk, led", {gpio[1], led}, 5'h10);
            @(negedge clk);
        end

        repeat (4) @(refresh_cnt);                      // Free running counter

        tm_pat = board_pkg::key_vec_t'($urandom) & 8'hfe | 8'h10;  // Key 0 left out
        next_refresh_start();
        pressed <= tm_pat;
        expect_leds(tm_pat, 3);

        board_pat = w_key'($urandom) & 4'he | 4'h2;
        next_refresh_start();
        pressed <= '0;
        key     <= board_pat;
        expect_leds(board_pat, 3);

        tm_pat = board_pkg::key_vec_t'($urandom) & 8'hfe | 8'h10;
        next_refresh_start();
        pressed <= tm_pat;
        expect_leds(tm_pat | board_pat, 3);             // ORed merge

        next_refresh_start();
        pressed <= '0;
        key     <= '0;
        expect_leds(8'h00, 3);

        next_refresh_start();
        key          <= 4'b0001;                        // Board key 0
        press_cycle  = cycle;
        clear_window = 4;
        repeat (2) @(refresh_cnt);
        check_cleared(press_cycle);
        @(posedge clk);
        key <= '0;

        next_refresh_start();
        pressed      <= 8'h01;                          // TM1638 key 0
        press_cycle  = cycle;
        clear_window = 4;
        repeat (3) @(refresh_cnt);                      // Key scan first, then two refreshes
        check_cleared(press_cycle);
        @(posedge clk);
        pressed <= '0;
        expect_leds(8'h00, 3);

        $display("Verification passed");
        $finish;
    end

endmodule

//--- list.f
source/board_pkg.sv
source/tick_gen.sv
source/key_merge.sv
source/lab_counter.sv
source/tm1638_controller.sv
source/board_top.sv
dv/tm1638_model.sv
dv/tb_board_top.sv

//--- Bender.yml
package:
  name: board_top

sources:
  - source/board_pkg.sv
  - source/tick_gen.sv
  - source/key_merge.sv
  - source/lab_counter.sv
  - source/tm1638_controller.sv
  - source/board_top.sv
  - target: simulation
    files:
      - dv/tm1638_model.sv
      - dv/tb_board_top.sv
